// File: logic/ifu_pkg.sv
/* IFU shared definitions
   Widths, queue geometry, memory response, instruction type and write-size codes */
package ifu_pkg;

    // Datapath
    localparam int XLEN   = 32;
    localparam int HALF_W = 16;

    // Instruction queue geometry
    localparam int Q_SIZE_WORD = 2;
    localparam int Q_SIZE_HALF = Q_SIZE_WORD * 2;
    localparam int Q_ADR_W     = $clog2(Q_SIZE_HALF);
    localparam int Q_PTR_W     = Q_ADR_W + 1;               // Extra wrap bit
    localparam int Q_FREE_W_W  = $clog2(Q_SIZE_WORD + 1);

    localparam int TXN_CNT_W   = 3;                         // All ones is the pending limit

    // Memory response codes
    localparam int                RESP_W      = 2;
    localparam logic [RESP_W-1:0] RESP_NOTRDY = 2'd0;
    localparam logic [RESP_W-1:0] RESP_RDY_OK = 2'd1;
    localparam logic [RESP_W-1:0] RESP_RDY_ER = 2'd2;

    // ----------------------------------------
    // Word type, upper half role then lower half role
    localparam int                      INSTR_TYPE_W     = 3;
    localparam logic [INSTR_TYPE_W-1:0] IT_NONE          = 3'd0;
    localparam logic [INSTR_TYPE_W-1:0] IT_RVI_HI_RVI_LO = 3'd1; // Whole aligned RVI
    localparam logic [INSTR_TYPE_W-1:0] IT_RVC_RVC       = 3'd2;
    localparam logic [INSTR_TYPE_W-1:0] IT_RVI_LO_RVC    = 3'd3;
    localparam logic [INSTR_TYPE_W-1:0] IT_RVC_RVI_HI    = 3'd4;
    localparam logic [INSTR_TYPE_W-1:0] IT_RVI_LO_RVI_HI = 3'd5;
    localparam logic [INSTR_TYPE_W-1:0] IT_RVC_NV        = 3'd6; // Lower half skipped
    localparam logic [INSTR_TYPE_W-1:0] IT_RVI_LO_NV     = 3'd7; // Lower half skipped

    // Queue write size
    localparam int                   WR_SIZE_W = 2;
    localparam logic [WR_SIZE_W-1:0] WR_NONE   = 2'b00;
    localparam logic [WR_SIZE_W-1:0] WR_FULL   = 2'b01;     // Both halfwords
    localparam logic [WR_SIZE_W-1:0] WR_HI     = 2'b10;     // Upper halfword only

    // Memory read word, whole or as two halfwords
    typedef union packed {
        logic [XLEN-1:0]            word;
        logic [1:0][HALF_W-1:0]     half;                   // Index 0 is the lower half
    } imem_word_u;

endpackage

// File: logic/imem_fetch_ctrl.sv
/* Instruction memory fetch controller
   Idle/fetch FSM, word address register, pending and discard counters */
`timescale 1ns/10ps

module imem_fetch_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stop_fetch_i,
    input  logic                            pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0]        pc_new_i,
    input  logic                            imem_req_ack_i,
    input  logic [ifu_pkg::XLEN-1:0]        imem_rdata_i,
    input  logic [ifu_pkg::RESP_W-1:0]      imem_resp_i,
    input  logic [ifu_pkg::Q_FREE_W_W-1:0]  q_free_words_i,     // After this cycle's read
    output logic                            imem_req_o,
    output logic [ifu_pkg::XLEN-1:0]        imem_addr_o,
    output ifu_pkg::imem_word_u             imem_rdata_o,
    output logic                            resp_ok_vd_o,
    output logic                            resp_er_vd_o
);

    logic                                   fetch_ff;           // 0 idle, 1 fetch
    logic                                   fetch_next;
    logic                                   fetch_req;
    logic                                   stop_req;

    logic                                   resp_ok;
    logic                                   resp_er;
    logic                                   resp_rcvd;
    logic                                   discard_req;
    logic                                   handshake;

    logic [ifu_pkg::XLEN-1:2]               addr_ff;            // Word address
    logic [ifu_pkg::XLEN-1:2]               addr_next;
    logic [ifu_pkg::XLEN-1:2]               addr_inc;

    logic [ifu_pkg::TXN_CNT_W-1:0]          pnd_cnt;
    logic [ifu_pkg::TXN_CNT_W-1:0]          pnd_cnt_next;
    logic [ifu_pkg::TXN_CNT_W-1:0]          vd_pnd_cnt;
    logic                                   pnd_full;
    logic                                   q_has_room;

    logic [ifu_pkg::TXN_CNT_W-1:0]          disc_cnt;
    logic [ifu_pkg::TXN_CNT_W-1:0]          disc_cnt_next;
    logic                                   disc_cnt_upd;

    // ----------------------------------------
    // Response decode
    assign resp_ok      = (imem_resp_i == ifu_pkg::RESP_RDY_OK);
    assign resp_er      = (imem_resp_i == ifu_pkg::RESP_RDY_ER);
    assign resp_rcvd    = resp_ok | resp_er;
    assign discard_req  = |disc_cnt;                            // Stale response in flight
    assign resp_ok_vd_o = resp_ok & ~discard_req;
    assign resp_er_vd_o = resp_er & ~discard_req;
    assign imem_rdata_o.word = imem_rdata_i;

    assign handshake = imem_req_o & imem_req_ack_i;

    // FSM, an accepted error parks it until the next redirect
    assign fetch_req  = pc_new_req_i & ~stop_fetch_i;
    assign stop_req   = stop_fetch_i | (resp_er_vd_o & ~pc_new_req_i);
    assign fetch_next = fetch_ff ? ~stop_req : fetch_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_ff <= 1'b0;
        end else begin
            fetch_ff <= fetch_next;
        end
    end

    // ----------------------------------------
    // Address register, redirect also counts a same-cycle acceptance
    assign addr_inc  = (ifu_pkg::XLEN-2)'(handshake);
    assign addr_next = pc_new_req_i  ? pc_new_i[ifu_pkg::XLEN-1:2] + addr_inc
                     : &addr_ff[5:2] ? addr_ff + addr_inc
                     : {addr_ff[ifu_pkg::XLEN-1:6], addr_ff[5:2] + 4'(handshake)};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
        end else if (handshake | pc_new_req_i) begin
            addr_ff <= addr_next;
        end
    end

    // Pending requests, up on acceptance and down on any response
    assign pnd_cnt_next = pnd_cnt + (ifu_pkg::TXN_CNT_W)'(handshake)
                                  - (ifu_pkg::TXN_CNT_W)'(resp_rcvd);
    assign pnd_full     = &pnd_cnt;                             // Limit of 7

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pnd_cnt <= '0;
        end else begin
            pnd_cnt <= pnd_cnt_next;
        end
    end

    // Discard counter swallows responses older than a redirect or an error
    assign disc_cnt_upd  = pc_new_req_i | resp_er | (resp_ok & discard_req);
    assign disc_cnt_next = pc_new_req_i ? pnd_cnt_next - (ifu_pkg::TXN_CNT_W)'(handshake)
                         : resp_er_vd_o ? pnd_cnt_next
                         : disc_cnt - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disc_cnt <= '0;
        end else if (disc_cnt_upd) begin
            disc_cnt <= disc_cnt_next;
        end
    end

    // ----------------------------------------
    // Request gating against queue room
    assign vd_pnd_cnt = pnd_cnt - disc_cnt;
    assign q_has_room = ((ifu_pkg::TXN_CNT_W)'(q_free_words_i) > vd_pnd_cnt);

    assign imem_req_o  = (pc_new_req_i & ~pnd_full & ~stop_fetch_i)
                       | (fetch_ff     & ~pnd_full & q_has_room);
    assign imem_addr_o = pc_new_req_i ? {pc_new_i[ifu_pkg::XLEN-1:2], 2'b00}
                                      : {addr_ff, 2'b00};

endmodule

// File: logic/instr_split_decoder.sv
/* Halfword split decoder
   Classifies each accepted read word into instruction parts, picks queue write size */
`timescale 1ns/10ps

module instr_split_decoder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0]        pc_new_i,
    input  ifu_pkg::imem_word_u             imem_rdata_i,
    input  logic                            resp_ok_vd_i,
    input  logic                            resp_er_vd_i,
    output logic [ifu_pkg::WR_SIZE_W-1:0]   wr_size_o,
    output logic                            new_pc_unaligned_o
);

    logic                                   resp_vd;
    logic                                   hi_is_rvi;
    logic                                   lo_is_rvi;
    logic [ifu_pkg::INSTR_TYPE_W-1:0]       instr_type;
    logic                                   hi_rvi_lo_ff;       // RVI began in last upper half
    logic                                   hi_rvi_lo_next;

    assign resp_vd   = resp_ok_vd_i | resp_er_vd_i;
    assign hi_is_rvi = &imem_rdata_i.half[1][1:0];              // Low bits 11 start an RVI
    assign lo_is_rvi = &imem_rdata_i.half[0][1:0];

    // ----------------------------------------
    // Unaligned redirect, first word only carries its upper half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_pc_unaligned_o <= 1'b0;
        end else if (pc_new_req_i) begin
            new_pc_unaligned_o <= pc_new_i[1];
        end else if (resp_vd) begin
            new_pc_unaligned_o <= 1'b0;
        end
    end

    // Word classification
    always_comb begin
        instr_type = ifu_pkg::IT_NONE;
        if (resp_ok_vd_i) begin
            if (new_pc_unaligned_o) begin
                instr_type = hi_is_rvi ? ifu_pkg::IT_RVI_LO_NV : ifu_pkg::IT_RVC_NV;
            end else if (hi_rvi_lo_ff) begin                    // Lower half ends an RVI
                instr_type = hi_is_rvi ? ifu_pkg::IT_RVI_LO_RVI_HI : ifu_pkg::IT_RVC_RVI_HI;
            end else if (lo_is_rvi) begin
                instr_type = ifu_pkg::IT_RVI_HI_RVI_LO;
            end else begin
                instr_type = hi_is_rvi ? ifu_pkg::IT_RVI_LO_RVC : ifu_pkg::IT_RVC_RVC;
            end
        end
    end

    // Upper half opens an RVI that ends in the next word
    assign hi_rvi_lo_next = (instr_type == ifu_pkg::IT_RVI_LO_NV)
                          | (instr_type == ifu_pkg::IT_RVI_LO_RVI_HI)
                          | (instr_type == ifu_pkg::IT_RVI_LO_RVC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi_rvi_lo_ff <= 1'b0;
        end else if (pc_new_req_i) begin
            hi_rvi_lo_ff <= 1'b0;
        end else if (resp_vd) begin
            hi_rvi_lo_ff <= hi_rvi_lo_next;
        end
    end

    // ----------------------------------------
    // Queue write size
    always_comb begin
        wr_size_o = ifu_pkg::WR_NONE;
        if (resp_ok_vd_i) begin
            case (instr_type)
                ifu_pkg::IT_RVC_NV,
                ifu_pkg::IT_RVI_LO_NV : wr_size_o = ifu_pkg::WR_HI;
                default               : wr_size_o = ifu_pkg::WR_FULL;
            endcase
        end else if (resp_er_vd_i) begin
            wr_size_o = ifu_pkg::WR_FULL;                       // Both halves flagged faulty
        end
    end

endmodule

// File: logic/instr_queue.sv
/* Instruction queue
   Four halfword slots with fault flags, pointers, status and instruction assembly */
`timescale 1ns/10ps

module instr_queue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pc_new_req_i,
    input  logic                            stop_fetch_i,
    input  ifu_pkg::imem_word_u             imem_rdata_i,
    input  logic                            resp_er_vd_i,
    input  logic [ifu_pkg::WR_SIZE_W-1:0]   wr_size_i,
    input  logic                            new_pc_unaligned_i,
    input  logic                            dec_rdy_i,
    output logic [ifu_pkg::Q_FREE_W_W-1:0]  q_free_words_o,
    output logic [ifu_pkg::XLEN-1:0]        instr_o,
    output logic                            imem_err_o,
    output logic                            err_rvi_hi_o,
    output logic                            instr_vd_o
);

    logic [ifu_pkg::HALF_W-1:0]             q_data [ifu_pkg::Q_SIZE_HALF];
    logic                                   q_err  [ifu_pkg::Q_SIZE_HALF];

    logic [ifu_pkg::Q_PTR_W-1:0]            wptr;
    logic [ifu_pkg::Q_PTR_W-1:0]            wptr_next;
    logic [ifu_pkg::Q_PTR_W-1:0]            rptr;
    logic [ifu_pkg::Q_PTR_W-1:0]            rptr_next;
    logic [ifu_pkg::Q_ADR_W-1:0]            wr_adr;
    logic [ifu_pkg::Q_ADR_W-1:0]            rd_adr;

    logic                                   flush;
    logic                                   wr_none;
    logic                                   wr_full;
    logic                                   wr_en;
    logic                                   rd_vd;
    logic                                   rd_hword;

    logic [ifu_pkg::HALF_W-1:0]             data_head;
    logic [ifu_pkg::HALF_W-1:0]             data_next;
    logic                                   err_head;
    logic                                   err_next;
    logic                                   head_is_rvi;

    logic [ifu_pkg::Q_PTR_W-1:0]            ocpd_h;             // Occupied halfwords
    logic [ifu_pkg::Q_PTR_W-1:0]            free_h_next;
    logic                                   is_empty;
    logic                                   one_ocpd_hw;

    assign flush   = pc_new_req_i | stop_fetch_i;
    assign wr_none = (wr_size_i == ifu_pkg::WR_NONE);
    assign wr_full = (wr_size_i == ifu_pkg::WR_FULL);
    assign wr_en   = ~wr_none & ~flush;

    // ----------------------------------------
    // Pointers, cleared by redirect or stop
    assign rd_vd    = instr_vd_o & dec_rdy_i;
    assign rd_hword = ~head_is_rvi | err_head;                  // Faulted head goes alone

    assign wptr_next = flush  ? '0
                     : wr_en  ? wptr + (wr_full ? 2'd2 : 2'd1)
                     : wptr;
    assign rptr_next = flush  ? '0
                     : rd_vd  ? rptr + (rd_hword ? 2'd1 : 2'd2)
                     : rptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            wptr <= wptr_next;
            rptr <= rptr_next;
        end
    end

    assign wr_adr = wptr[ifu_pkg::Q_ADR_W-1:0];
    assign rd_adr = rptr[ifu_pkg::Q_ADR_W-1:0];

    // Slot storage, first slot takes the upper half after an unaligned redirect
    always_ff @(posedge clk) begin
        if (wr_en) begin
            q_data[wr_adr] <= imem_rdata_i.half[new_pc_unaligned_i];
            q_err[wr_adr]  <= resp_er_vd_i;
            if (wr_full) begin
                q_data[wr_adr + 1'b1] <= imem_rdata_i.half[1];
                q_err[wr_adr + 1'b1]  <= resp_er_vd_i;
            end
        end
    end

    assign data_head   = q_data[rd_adr];
    assign data_next   = q_data[rd_adr + 1'b1];
    assign err_head    = q_err[rd_adr];
    assign err_next    = q_err[rd_adr + 1'b1];
    assign head_is_rvi = &data_head[1:0];

    // ----------------------------------------
    // Status
    assign ocpd_h         = wptr - rptr;
    assign free_h_next    = (ifu_pkg::Q_PTR_W)'(ifu_pkg::Q_SIZE_HALF) - (wptr - rptr_next);
    assign q_free_words_o = free_h_next[ifu_pkg::Q_PTR_W-1:1];  // Whole words only
    assign is_empty       = (rptr == wptr);
    assign one_ocpd_hw    = (ocpd_h == (ifu_pkg::Q_PTR_W)'(1));

    // Decoder side flags
    always_comb begin
        instr_vd_o   = 1'b0;
        imem_err_o   = 1'b0;
        err_rvi_hi_o = 1'b0;
        if (!is_empty) begin
            if (one_ocpd_hw) begin                              // RVI tail not yet here
                instr_vd_o = ~head_is_rvi | err_head;
                imem_err_o = err_head;
            end else begin
                instr_vd_o   = 1'b1;
                imem_err_o   = err_head | (head_is_rvi & err_next);
                err_rvi_hi_o = ~err_head & head_is_rvi & err_next;
            end
        end
    end

    // Output instruction, RVC zero-extended
    assign instr_o = head_is_rvi ? {data_next, data_head}
                                 : {{ifu_pkg::HALF_W{1'b0}}, data_head};

endmodule

// File: logic/ifu_top.sv
/* Instruction fetch unit top
   Memory fetch controller, halfword split decoder and instruction queue */
`timescale 1ns/10ps

module ifu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stop_fetch_i,
    // Instruction memory
    input  logic                            imem_req_ack_i,
    input  logic [ifu_pkg::XLEN-1:0]        imem_rdata_i,
    input  logic [ifu_pkg::RESP_W-1:0]      imem_resp_i,
    output logic                            imem_req_o,
    output logic [ifu_pkg::XLEN-1:0]        imem_addr_o,
    // Redirect from the core
    input  logic                            pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0]        pc_new_i,
    // Decoder side
    input  logic                            dec_rdy_i,
    output logic [ifu_pkg::XLEN-1:0]        instr_o,
    output logic                            imem_err_o,
    output logic                            err_rvi_hi_o,
    output logic                            instr_vd_o
);

    logic                                   resp_ok_vd;         // Accepted OK response
    logic                                   resp_er_vd;         // Accepted ER response
    ifu_pkg::imem_word_u                    imem_rdata;
    logic [ifu_pkg::Q_FREE_W_W-1:0]         q_free_words;
    logic [ifu_pkg::WR_SIZE_W-1:0]          wr_size;
    logic                                   new_pc_unaligned;

    imem_fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .stop_fetch_i   (stop_fetch_i),
        .pc_new_req_i   (pc_new_req_i),
        .pc_new_i       (pc_new_i),
        .imem_req_ack_i (imem_req_ack_i),
        .imem_rdata_i   (imem_rdata_i),
        .imem_resp_i    (imem_resp_i),
        .q_free_words_i (q_free_words),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_o   (imem_rdata),
        .resp_ok_vd_o   (resp_ok_vd),
        .resp_er_vd_o   (resp_er_vd)
    );

    instr_split_decoder u_split_dec (
        .clk                (clk),
        .rst_n              (rst_n),
        .pc_new_req_i       (pc_new_req_i),
        .pc_new_i           (pc_new_i),
        .imem_rdata_i       (imem_rdata),
        .resp_ok_vd_i       (resp_ok_vd),
        .resp_er_vd_i       (resp_er_vd),
        .wr_size_o          (wr_size),
        .new_pc_unaligned_o (new_pc_unaligned)
    );

    instr_queue u_instr_queue (
        .clk                (clk),
        .rst_n              (rst_n),
        .pc_new_req_i       (pc_new_req_i),
        .stop_fetch_i       (stop_fetch_i),
        .imem_rdata_i       (imem_rdata),
        .resp_er_vd_i       (resp_er_vd),
        .wr_size_i          (wr_size),
        .new_pc_unaligned_i (new_pc_unaligned),
        .dec_rdy_i          (dec_rdy_i),
        .q_free_words_o     (q_free_words),
        .instr_o            (instr_o),
        .imem_err_o         (imem_err_o),
        .err_rvi_hi_o       (err_rvi_hi_o),
        .instr_vd_o         (instr_vd_o)
    );

endmodule

// File: sim/clk_gen.sv
/* Clock and reset source
   4 ns clock, active-low reset held for the first 5 cycles */
`timescale 1ns/10ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 2;                 // ns
    localparam int RST_CYCLES  = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;                          // Release just after an edge
    end

endmodule

// File: sim/ifu_properties.sv
/* Fetch unit interface checks
   Bound into the top level, covers request rules, flushes and decoder hold */
`timescale 1ns/10ps

module ifu_properties (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stop_fetch_i,
    input  logic                            pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0]        pc_new_i,
    input  logic                            imem_req_i,
    input  logic                            imem_req_ack_i,
    input  logic [ifu_pkg::XLEN-1:0]        imem_addr_i,
    input  logic [ifu_pkg::RESP_W-1:0]      imem_resp_i,
    input  logic                            resp_er_vd_i,
    input  logic                            dec_rdy_i,
    input  logic                            instr_vd_i,
    input  logic [ifu_pkg::XLEN-1:0]        instr_i,
    input  logic                            imem_err_i,
    input  logic                            err_rvi_hi_i
);

    int unsigned                            fail_cnt = 0;       // Failed assertions so far
    logic [3:0]                             txn_cnt;            // Requests without a response
    logic                                   parked;             // Idle until the next redirect
    logic                                   hs;
    logic                                   rsp;
    logic [ifu_pkg::XLEN-1:0]               exp_addr;           // Next word after last accept
    logic [ifu_pkg::XLEN-1:0]               req_addr;           // Address due this cycle

    assign hs  = imem_req_i & imem_req_ack_i;
    assign rsp = (imem_resp_i == ifu_pkg::RESP_RDY_OK) | (imem_resp_i == ifu_pkg::RESP_RDY_ER);

    // Redirect target word, else the word after the last accepted one
    assign req_addr = pc_new_req_i ? {pc_new_i[ifu_pkg::XLEN-1:2], 2'b00} : exp_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_cnt  <= '0;
            parked   <= 1'b1;                                   // Idle out of reset
            exp_addr <= '0;
        end else begin
            txn_cnt <= txn_cnt + 4'(hs) - 4'(rsp);
            if (pc_new_req_i || hs) begin
                exp_addr <= req_addr + (hs ? 32'd4 : 32'd0);
            end
            if (pc_new_req_i && !stop_fetch_i) begin
                parked <= 1'b0;
            end else if (stop_fetch_i || resp_er_vd_i) begin
                parked <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_i |-> (imem_addr_i == req_addr))
        else begin fail_cnt++; $error("request address is not the next aligned word"); end

    a_txn_limit: assert property (@(posedge clk) disable iff (!rst_n)
        txn_cnt <= 4'd7)
        else begin fail_cnt++; $error("more than 7 requests outstanding"); end

    a_parked_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        (parked && !pc_new_req_i) |-> !imem_req_i)
        else begin fail_cnt++; $error("request while idle after error or stop"); end

    // Flushes
    a_stop_flush: assert property (@(posedge clk) disable iff (!rst_n)
        stop_fetch_i |=> !instr_vd_i)
        else begin fail_cnt++; $error("instruction valid right after stop"); end

    a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
        pc_new_req_i |=> !instr_vd_i)
        else begin fail_cnt++; $error("instruction valid right after redirect"); end

    // Decoder hold, nothing moves while stalled
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_vd_i && !dec_rdy_i && !pc_new_req_i && !stop_fetch_i)
        |=> (instr_vd_i && $stable(instr_i) && $stable(imem_err_i) && $stable(err_rvi_hi_i)))
        else begin fail_cnt++; $error("output changed while decoder stalled"); end

endmodule

bind ifu_top ifu_properties u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .stop_fetch_i   (stop_fetch_i),
    .pc_new_req_i   (pc_new_req_i),
    .pc_new_i       (pc_new_i),
    .imem_req_i     (imem_req_o),
    .imem_req_ack_i (imem_req_ack_i),
    .imem_addr_i    (imem_addr_o),
    .imem_resp_i    (imem_resp_i),
    .resp_er_vd_i   (resp_er_vd),
    .dec_rdy_i      (dec_rdy_i),
    .instr_vd_i     (instr_vd_o),
    .instr_i        (instr_o),
    .imem_err_i     (imem_err_o),
    .err_rvi_hi_i   (err_rvi_hi_o)
);

// File: sim/ifu_tb.sv
/* Fetch unit testbench
   Random memory model, redirect, fault, stop and stall stimulus, reference walk checks */
`timescale 1ns/10ps

module ifu_tb;

    localparam int N_PHASES    = 4;
    localparam int PHASE_CYC   = 400;
    localparam int TIMEOUT_CYC = N_PHASES * PHASE_CYC * 5 / 2;  // Margin over the phases

    logic                           clk;
    logic                           rst_n;
    logic                           stop_fetch_i   = 1'b0;
    logic                           imem_req_ack_i = 1'b0;
    logic [ifu_pkg::XLEN-1:0]       imem_rdata_i   = '0;
    logic [ifu_pkg::RESP_W-1:0]     imem_resp_i    = ifu_pkg::RESP_NOTRDY;
    logic                           pc_new_req_i   = 1'b0;
    logic [ifu_pkg::XLEN-1:0]       pc_new_i       = '0;
    logic                           dec_rdy_i      = 1'b0;
    logic                           imem_req_o;
    logic [ifu_pkg::XLEN-1:0]       imem_addr_o;
    logic [ifu_pkg::XLEN-1:0]       instr_o;
    logic                           imem_err_o;
    logic                           err_rvi_hi_o;
    logic                           instr_vd_o;

    logic [31:0]                    mem [256];
    logic                           er_mark [256];              // Word answers ER
    logic [31:0]                    rsp_addr_q [$];
    int unsigned                    rsp_due_q [$];
    int unsigned                    cyc      = 0;
    int unsigned                    last_due = 0;
    int unsigned                    err_cnt  = 0;
    int unsigned                    n_seen   = 0;               // Instructions checked
    logic [31:0]                    exp_pc   = '0;              // Reference walk position
    logic                           checking = 1'b0;
    logic                           hold_rdy = 1'b0;

    clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    ifu_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .stop_fetch_i   (stop_fetch_i),
        .imem_req_ack_i (imem_req_ack_i),
        .imem_rdata_i   (imem_rdata_i),
        .imem_resp_i    (imem_resp_i),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .pc_new_req_i   (pc_new_req_i),
        .pc_new_i       (pc_new_i),
        .dec_rdy_i      (dec_rdy_i),
        .instr_o        (instr_o),
        .imem_err_o     (imem_err_o),
        .err_rvi_hi_o   (err_rvi_hi_o),
        .instr_vd_o     (instr_vd_o)
    );

    function automatic logic [15:0] half_at(input logic [31:0] addr);
        return addr[1] ? mem[addr[9:2]][31:16] : mem[addr[9:2]][15:0];
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("error %0t ns %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic print_summary();
        $display("summary: %0d instructions checked, %0d check errors, %0d assertion failures",
                 n_seen, err_cnt, dut0.u_props.fail_cnt);
    endtask

    // ----------------------------------------
    // Memory model, random ack, in-order answers 1 to 3 cycles later
    always @(posedge clk) begin : mem_model
        int unsigned due;
        logic [31:0] addr;
        if (imem_req_o && imem_req_ack_i) begin
            due = cyc + 1 + $urandom_range(2);
            if (due <= last_due) due = last_due + 1;            // One answer per cycle
            rsp_addr_q.push_back(imem_addr_o);
            rsp_due_q.push_back(due);
            last_due = due;
        end
        cyc = cyc + 1;
        #1;
        imem_req_ack_i = ($urandom_range(3) != 0);
        if (rsp_due_q.size() != 0 && rsp_due_q[0] == cyc) begin
            addr = rsp_addr_q.pop_front();
            void'(rsp_due_q.pop_front());
            imem_rdata_i = mem[addr[9:2]];
            imem_resp_i  = er_mark[addr[9:2]] ? ifu_pkg::RESP_RDY_ER : ifu_pkg::RESP_RDY_OK;
        end else begin
            imem_rdata_i = $urandom();                          // Junk, must be ignored
            imem_resp_i  = ifu_pkg::RESP_NOTRDY;
        end
    end

    // Decoder ready, random unless held low
    always @(posedge clk) begin : rdy_drive
        logic hold;
        hold = hold_rdy;
        #1;
        dec_rdy_i = ~hold & ($urandom_range(3) != 0);
    end

    // ----------------------------------------
    // Reference walk, low bits 11 open an RVI
    always @(posedge clk) begin : ref_check
        logic [31:0] nxt_pc;
        logic [15:0] lo;
        logic [15:0] hi;
        logic        rvi;
        logic        er_lo;
        logic        er_hi;
        logic        exp_err;
        logic        exp_err_hi;
        logic [31:0] exp_instr;
        if (pc_new_req_i) begin
            exp_pc   = pc_new_i;
            checking = ~stop_fetch_i;
        end else if (stop_fetch_i) begin
            checking = 1'b0;
        end else if (rst_n && checking && instr_vd_o && dec_rdy_i) begin
            nxt_pc     = exp_pc + 32'd2;
            lo         = half_at(exp_pc);
            hi         = half_at(nxt_pc);
            rvi        = &lo[1:0];
            er_lo      = er_mark[exp_pc[9:2]];
            er_hi      = er_mark[nxt_pc[9:2]];
            exp_err    = er_lo | (rvi & er_hi);
            exp_err_hi = ~er_lo & rvi & er_hi;                  // Only the tail faulted
            exp_instr  = rvi ? {hi, lo} : {16'h0000, lo};
            assert (imem_err_o == exp_err)
                else log_mismatch("imem_err_o", 32'(imem_err_o), 32'(exp_err));
            assert (err_rvi_hi_o == exp_err_hi)
                else log_mismatch("err_rvi_hi_o", 32'(err_rvi_hi_o), 32'(exp_err_hi));
            assert (exp_err || instr_o == exp_instr)            // Faulted data is don't care
                else log_mismatch("instr_o", instr_o, exp_instr);
            exp_pc = (rvi && !er_lo) ? exp_pc + 32'd4 : nxt_pc; // Faulted head goes alone
            n_seen++;
        end
    end

    // ----------------------------------------
    task automatic redirect(input logic [31:0] pc);
        pc_new_req_i = 1'b1;
        pc_new_i     = pc;
        @(posedge clk);
        #1;
        pc_new_req_i = 1'b0;
    endtask

    task automatic wait_instr(input int unsigned n);
        int unsigned target;
        target = n_seen + n;
        while (n_seen < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_quiet(input string what);
        assert (!instr_vd_o) else begin
            $display("error %0t ns: instruction still offered after %s", $time, what);
            err_cnt++;
        end
    endtask

    initial begin : stimulus
        void'($urandom(32'h68b5));
        foreach (mem[i]) begin
            mem[i]     = $urandom();
            er_mark[i] = 1'b0;
        end
        er_mark[200]    = 1'b1;
        er_mark[230]    = 1'b1;
        mem[199][1:0]   = 2'b00;                                // RVC, then RVI into word 200
        mem[199][17:16] = 2'b11;

        wait (rst_n);
        @(posedge clk);
        #1;
        redirect(32'h0000_0000);                                // Aligned start
        wait_instr(150);
        redirect(32'h0000_0192);                                // Unaligned, requests in flight
        wait_instr(40);
        redirect(32'h0000_1046);
        wait_instr(40);

        redirect(32'h0000_031C);                                // RVI with faulted upper half
        wait_instr(3);
        idle_cycles(20);
        check_quiet("a fault in the upper half");
        redirect(32'h0000_0398);                                // Faulted first word
        wait_instr(2);
        idle_cycles(20);
        check_quiet("a faulted word");

        redirect(32'h0000_0800);
        wait_instr(20);
        stop_fetch_i = 1'b1;
        idle_cycles(12);
        check_quiet("stop");
        stop_fetch_i = 1'b0;
        redirect(32'h0000_0C0A);

        hold_rdy = 1'b1;                                        // Let the queue fill
        idle_cycles(40);
        hold_rdy = 1'b0;
        wait_instr(60);
        idle_cycles(10);

        print_summary();
        if (err_cnt == 0 && dut0.u_props.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout: run not done after %0d cycles, %0d instructions seen",
                 TIMEOUT_CYC, n_seen);
        print_summary();
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: ifu_top.f
logic/ifu_pkg.sv
logic/imem_fetch_ctrl.sv
logic/instr_split_decoder.sv
logic/instr_queue.sv
logic/ifu_top.sv
sim/clk_gen.sv
sim/ifu_properties.sv
sim/ifu_tb.sv

// File: Bender.yml
package:
  name: ifu

sources:
  # Package first, then leaf modules, then the top level
  - logic/ifu_pkg.sv
  - logic/imem_fetch_ctrl.sv
  - logic/instr_split_decoder.sv
  - logic/instr_queue.sv
  - logic/ifu_top.sv

  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/ifu_properties.sv
      - sim/ifu_tb.sv
